/* Makefile */
TOP = tb_loader_top
LOG = sim.log

.PHONY: all lint clean

all:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f verilog.f
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "Simulation finished: PASS" $(LOG)

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f verilog.f

clean:
	rm -rf obj_dir $(LOG)

/* bench/loader_top_sva.sv */
`timescale 1ns/1ps
`default_nettype none

// Bus protocol rules seen at the loader_top ports
module loader_top_sva
(
  input wire                    clk_cpu,
  input wire                    i_rst_n,
  input wire                    i_cpu_as_n,
  input wire                    i_loader_mode,
  input wire                    i_spi_miso,
  input wire loader_pkg::word_t i_cpu_din,
  input wire                    i_cpu_dtack_n,
  input wire                    i_cpu_halt_n,
  input wire                    i_cpu_reset
);

  int fail_count = 0;  // Number of failed assertions

  // ==================================================
  // DTACK rules
  // ==================================================
  // DTACK only after AS has been held low through the access
  dtack_needs_as: assert property
    (@(posedge clk_cpu) disable iff (!i_rst_n)
      !i_cpu_dtack_n |-> !i_cpu_as_n && $past(!i_cpu_as_n) && $past(!i_cpu_as_n, 2))
    else
    begin
      $error("DTACK low without AS held low");
      fail_count++;
    end

  // CPU stalls while the loader owns the RAM and one cycle beyond
  dtack_held_in_loader_mode: assert property
    (@(posedge clk_cpu) disable iff (!i_rst_n)
      (i_loader_mode || $past(i_loader_mode)) |-> i_cpu_dtack_n)
    else
    begin
      $error("DTACK low in or right after loader mode");
      fail_count++;
    end

  // ==================================================
  // Known outputs
  // ==================================================
  outputs_known: assert property
    (@(posedge clk_cpu) disable iff (!i_rst_n)
      !$isunknown({i_spi_miso, i_cpu_din, i_cpu_dtack_n, i_cpu_halt_n, i_cpu_reset}))
    else
    begin
      $error("Unknown value on a loader_top output");
      fail_count++;
    end

endmodule

bind loader_top loader_top_sva sva_i
(
  .clk_cpu       (clk_cpu),
  .i_rst_n       (i_rst_n),
  .i_cpu_as_n    (i_cpu_as_n),
  .i_loader_mode (loader_mode),  // Internal ownership flag
  .i_spi_miso    (o_spi_miso),
  .i_cpu_din     (o_cpu_din),
  .i_cpu_dtack_n (o_cpu_dtack_n),
  .i_cpu_halt_n  (o_cpu_halt_n),
  .i_cpu_reset   (o_cpu_reset)
);

`default_nettype wire

/* bench/tb_clock_gen.sv */
`timescale 1ns/1ps
`default_nettype none

// Free-running clk_cpu and power-on reset for the testbench
module tb_clock_gen
(
  output logic clk_cpu,
  output logic o_rst_n
);

  initial
  begin
    clk_cpu = 1'b0;
    forever #2 clk_cpu = ~clk_cpu;  // 4 ns period
  end

  initial
  begin
    o_rst_n = 1'b0;
    repeat (16) @(negedge clk_cpu);  // 16 cycles in reset
    o_rst_n = 1'b1;                  // Release on a falling edge
  end

endmodule

`default_nettype wire

/* bench/tb_loader_top.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_loader_top;
  import loader_pkg::*;

  localparam int SPI_HALF   = 5;    // sclk half period in clk_cpu cycles
  localparam int DTACK_WAIT = 20;   // Normal bus cycle limit
  localparam int BUSY_WAIT  = 60;   // Stall window in loader mode
  localparam int RST_WAIT   = 100;
  localparam int REF_WORDS  = 16;

  logic      clk_cpu;
  logic      rst_n;
  logic      spi_csn;
  logic      spi_sclk;
  logic      spi_mosi;
  logic      spi_miso;
  logic      cpu_as_n;
  logic      cpu_rw;
  logic      cpu_uds_n;
  logic      cpu_lds_n;
  cpu_addr_t cpu_addr;
  word_t     cpu_dout;
  word_t     cpu_din;
  logic      cpu_dtack_n;
  logic      cpu_halt_n;
  logic      cpu_reset;

  int    value_errors;
  int    other_errors;
  int    seed;
  byte_t tx_buf  [0:31];
  byte_t rx_buf  [0:31];
  word_t ref_ram [0:REF_WORDS-1];  // Expected contents of words 0 to 15

  tb_clock_gen clk_gen_i
  (
    .clk_cpu (clk_cpu),
    .o_rst_n (rst_n)
  );

  loader_top
  #(
    .p_ram_words_log2 (10)
  )
  dut_i
  (
    .clk_cpu       (clk_cpu),
    .i_rst_n       (rst_n),
    .i_spi_csn     (spi_csn),
    .i_spi_sclk    (spi_sclk),
    .i_spi_mosi    (spi_mosi),
    .o_spi_miso    (spi_miso),
    .i_cpu_as_n    (cpu_as_n),
    .i_cpu_rw      (cpu_rw),
    .i_cpu_uds_n   (cpu_uds_n),
    .i_cpu_lds_n   (cpu_lds_n),
    .i_cpu_addr    (cpu_addr),
    .i_cpu_dout    (cpu_dout),
    .o_cpu_din     (cpu_din),
    .o_cpu_dtack_n (cpu_dtack_n),
    .o_cpu_halt_n  (cpu_halt_n),
    .o_cpu_reset   (cpu_reset)
  );

  // ==================================================
  // Compare tasks
  // ==================================================
  task automatic check_word(input string name, input word_t got, input word_t exp);
    if (got !== exp)
    begin
      value_errors++;
      $display("[ERROR] %0t %s got 0x%04h expected 0x%04h", $time, name, got, exp);
    end
  endtask

  task automatic check_byte(input string name, input byte_t got, input byte_t exp);
    if (got !== exp)
    begin
      value_errors++;
      $display("[ERROR] %0t %s got 0x%02h expected 0x%02h", $time, name, got, exp);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp)
    begin
      value_errors++;
      $display("[ERROR] %0t %s got %b expected %b", $time, name, got, exp);
    end
  endtask

  // ==================================================
  // SPI master in mode 0 with MSB first
  // ==================================================
  task automatic shift_spi_byte(input byte_t tx, output byte_t rx);
    int i;
    for (i = 7; i >= 0; i--)
    begin
      spi_mosi = tx[i];                  // Changes while sclk is low
      repeat (SPI_HALF) @(negedge clk_cpu);
      rx[i]    = spi_miso;               // Sampled at the rising edge
      spi_sclk = 1'b1;
      repeat (SPI_HALF) @(negedge clk_cpu);
      spi_sclk = 1'b0;
    end
  endtask

  // Command byte then 4 address bytes MSB first
  task automatic start_frame(input byte_t cmd, input spi_addr_t addr);
    byte_t unused_rx;
    int    b;
    spi_csn = 1'b0;
    repeat (SPI_HALF) @(negedge clk_cpu);
    shift_spi_byte(cmd, unused_rx);
    for (b = 3; b >= 0; b--)
      shift_spi_byte(byte_t'(addr >> (8 * b)), unused_rx);
  endtask

  task automatic end_frame;
    repeat (SPI_HALF) @(negedge clk_cpu);
    spi_csn = 1'b1;
    repeat (4 * SPI_HALF) @(negedge clk_cpu);  // Slave sees the deselect
  endtask

  task automatic spi_write_bytes(input spi_addr_t addr, input int count);
    byte_t unused_rx;
    int    k;
    start_frame(CMD_WRITE, addr);
    for (k = 0; k < count; k++)
      shift_spi_byte(tx_buf[k], unused_rx);
    end_frame();
  endtask

  task automatic spi_read_bytes(input spi_addr_t addr, input int count);
    byte_t unused_rx;
    int    k;
    start_frame(CMD_READ, addr);
    shift_spi_byte(8'h00, unused_rx);  // Dummy byte
    for (k = 0; k < count; k++)
      shift_spi_byte(8'h00, rx_buf[k]);
    end_frame();
  endtask

  task automatic set_ctrl(input byte_t value);
    byte_t unused_rx;
    start_frame(CMD_WRITE, {REGION_CTRL, 24'h000000});
    shift_spi_byte(value, unused_rx);
    end_frame();
  endtask

  // ==================================================
  // 68000 bus master
  // ==================================================
  task automatic bus_cycle(input cpu_addr_t addr, input logic rw, input byte_en_t lanes,
                           input word_t wdata, input int max_cycles, input logic expect_ack,
                           output word_t rdata);
    logic acked;
    int   n;
    acked     = 1'b0;
    rdata     = '0;
    cpu_addr  = addr;
    cpu_rw    = rw;
    cpu_dout  = wdata;
    cpu_uds_n = ~lanes[1];
    cpu_lds_n = ~lanes[0];
    cpu_as_n  = 1'b0;
    n = 0;
    while (n < max_cycles && !acked)
    begin
      @(negedge clk_cpu);
      n++;
      if (cpu_dtack_n == 1'b0)
      begin
        acked = 1'b1;
        rdata = cpu_din;  // Valid with DTACK
      end
    end
    cpu_as_n  = 1'b1;
    cpu_uds_n = 1'b1;
    cpu_lds_n = 1'b1;
    cpu_rw    = 1'b1;
    @(negedge clk_cpu);
    check_bit("o_cpu_dtack_n", cpu_dtack_n, 1'b1);  // Released with AS
    if (expect_ack && !acked)
    begin
      other_errors++;
      $display("%0t No DTACK within %0d cycles at word 0x%06h", $time, max_cycles, addr);
    end
    else if (!expect_ack && acked)
    begin
      other_errors++;
      $display("%0t DTACK arrived while the loader owned the RAM", $time);
    end
  endtask

  task automatic cpu_write(input cpu_addr_t addr, input word_t data, input byte_en_t lanes);
    word_t unused_rd;
    bus_cycle(addr, 1'b0, lanes, data, DTACK_WAIT, 1'b1, unused_rd);
  endtask

  task automatic cpu_read(input cpu_addr_t addr, output word_t data);
    bus_cycle(addr, 1'b1, 2'b11, 16'h0000, DTACK_WAIT, 1'b1, data);
  endtask

  // ==================================================
  // Directed tests
  // ==================================================
  task automatic after_reset_state;
    check_bit("o_cpu_halt_n", cpu_halt_n, 1'b0);  // CTRL_INIT halts the CPU
    check_bit("o_cpu_reset", cpu_reset, 1'b0);
    check_bit("o_cpu_dtack_n", cpu_dtack_n, 1'b1);
    check_bit("o_spi_miso", spi_miso, 1'b0);
  endtask

  task automatic loader_write_cpu_read;
    word_t rd;
    int    k;
    set_ctrl(8'h02);  // Loader owns the RAM
    for (k = 0; k < 8; k++)
      tx_buf[k] = byte_t'(8'hA1 + 8'h11 * k);
    spi_write_bytes(32'h0000_0000, 8);
    for (k = 0; k < 4; k++)
      ref_ram[k] = {tx_buf[2 * k], tx_buf[2 * k + 1]};  // Big-endian pairs
    set_ctrl(8'h00);
    check_bit("o_cpu_halt_n", cpu_halt_n, 1'b1);
    for (k = 0; k < 4; k++)
    begin
      cpu_read(cpu_addr_t'(k), rd);
      check_word("o_cpu_din", rd, ref_ram[k]);
    end
  endtask

  task automatic byte_lane_write;
    word_t rd;
    int    k;
    cpu_write(23'd1, 16'h5A3C, 2'b10);  // Upper lane only
    ref_ram[1][15:8] = 8'h5A;
    cpu_read(23'd1, rd);
    check_word("o_cpu_din", rd, ref_ram[1]);
    cpu_write(23'd2, 16'hC3E1, 2'b01);  // Lower lane only
    ref_ram[2][7:0] = 8'hE1;
    cpu_read(23'd2, rd);
    check_word("o_cpu_din", rd, ref_ram[2]);
    set_ctrl(8'h02);
    spi_read_bytes(32'h0000_0000, 8);
    for (k = 0; k < 8; k++)
      check_byte("o_spi_miso", rx_buf[k],
                 k[0] ? ref_ram[k / 2][7:0] : ref_ram[k / 2][15:8]);
  endtask

  task automatic loader_back_pressure;
    word_t rd;
    // Loader mode still on from the lane test
    bus_cycle(23'd0, 1'b1, 2'b11, 16'h0000, BUSY_WAIT, 1'b0, rd);
    set_ctrl(8'h00);
    cpu_read(23'd0, rd);  // Retry once the RAM is free
    check_word("o_cpu_din", rd, ref_ram[0]);
  endtask

  task automatic ctrl_and_regions;
    set_ctrl(8'h01);
    check_bit("o_cpu_reset", cpu_reset, 1'b1);
    check_bit("o_cpu_halt_n", cpu_halt_n, 1'b1);
    set_ctrl(8'h04);
    check_bit("o_cpu_reset", cpu_reset, 1'b0);
    check_bit("o_cpu_halt_n", cpu_halt_n, 1'b0);
    set_ctrl(8'h02);
    tx_buf[0] = 8'hEE;
    tx_buf[1] = 8'h77;
    spi_write_bytes(32'h1200_0000, 2);  // Unmapped region must not reach word 0
    spi_read_bytes(32'h0000_0000, 2);
    check_byte("o_spi_miso", rx_buf[0], ref_ram[0][15:8]);
    check_byte("o_spi_miso", rx_buf[1], ref_ram[0][7:0]);
    spi_read_bytes(32'h1200_0000, 1);
    check_byte("o_spi_miso", rx_buf[0], 8'h00);
    spi_read_bytes({REGION_CTRL, 24'h000000}, 1);
    check_byte("o_spi_miso", rx_buf[0], 8'h02);
  endtask

  task automatic random_round_trip;
    int rnd;
    int k;
    for (k = 0; k < 32; k++)
    begin
      rnd       = $random(seed);
      tx_buf[k] = rnd[7:0];
    end
    spi_write_bytes(32'h0000_0040, 32);  // Clear of words 0 to 15
    spi_read_bytes(32'h0000_0040, 32);
    for (k = 0; k < 32; k++)
      check_byte("o_spi_miso", rx_buf[k], tx_buf[k]);
  endtask

  // ==================================================
  // Main sequence
  // ==================================================
  initial
  begin
    int n;
    int sva_fails;
    value_errors = 0;
    other_errors = 0;
    seed         = 55046;
    spi_csn      = 1'b1;  // Idle bus
    spi_sclk     = 1'b0;
    spi_mosi     = 1'b0;
    cpu_as_n     = 1'b1;
    cpu_rw       = 1'b1;
    cpu_uds_n    = 1'b1;
    cpu_lds_n    = 1'b1;
    cpu_addr     = '0;
    cpu_dout     = '0;
    n = 0;
    while (rst_n !== 1'b1 && n < RST_WAIT)
    begin
      @(negedge clk_cpu);
      n++;
    end
    if (rst_n !== 1'b1)
    begin
      other_errors++;
      $display("%0t Reset was never released", $time);
    end
    @(negedge clk_cpu);
    after_reset_state();
    loader_write_cpu_read();
    byte_lane_write();
    loader_back_pressure();
    ctrl_and_regions();
    random_round_trip();
    sva_fails = dut_i.sva_i.fail_count;
    $display("Errors: %0d value mismatches, %0d protocol or timeout, %0d assertion failures",
             value_errors, other_errors, sva_fails);
    if (value_errors == 0 && other_errors == 0 && sva_fails == 0)
      $display("Simulation finished: PASS");
    else
      $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

/* hdl/loader_pkg.sv */
`default_nettype none

package loader_pkg;

  // ==================================================
  // Widths and types
  // ==================================================
  localparam int SPI_ADDR_W = 32;  // Loader byte address
  localparam int CPU_ADDR_W = 23;  // CPU word address 23:1
  localparam int WORD_W     = 16;
  localparam int BYTE_W     = 8;

  typedef logic [SPI_ADDR_W-1:0] spi_addr_t;
  typedef logic [CPU_ADDR_W-1:0] cpu_addr_t;
  typedef logic [WORD_W-1:0]     word_t;      // Big-endian RAM word
  typedef logic [BYTE_W-1:0]     byte_t;
  typedef logic [1:0]            byte_en_t;   // 1 upper lane, 0 lower lane

  // ==================================================
  // Loader address regions and control register
  // ==================================================
  // Region code sits in address bits 31:24
  localparam byte_t REGION_RAM  = 8'h00;
  localparam byte_t REGION_CTRL = 8'hFF;

  localparam int CTRL_RESET_BIT  = 0;  // Holds CPU in reset
  localparam int CTRL_LOADER_BIT = 1;  // Loader owns the RAM
  localparam int CTRL_HALT_BIT   = 2;  // Holds CPU halted

  // Start halted so the CPU never runs an empty RAM
  localparam byte_t CTRL_INIT = 8'h04;

  // ==================================================
  // SPI command bytes
  // ==================================================
  localparam byte_t CMD_WRITE = 8'h00;
  localparam byte_t CMD_READ  = 8'h01;  // One dummy byte after address

endpackage

`default_nettype wire

/* hdl/loader_top.sv */
`timescale 1ns/1ps
`default_nettype none

module loader_top
#(
  parameter int p_ram_words_log2 = 10  // RAM depth in words, log2
)
(
  input  wire                        clk_cpu,
  input  wire                        i_rst_n,
  // SPI slave from host
  input  wire                        i_spi_csn,
  input  wire                        i_spi_sclk,
  input  wire                        i_spi_mosi,
  output logic                       o_spi_miso,
  // 68000 bus
  input  wire                        i_cpu_as_n,
  input  wire                        i_cpu_rw,     // 1 read, 0 write
  input  wire                        i_cpu_uds_n,
  input  wire                        i_cpu_lds_n,
  input  wire loader_pkg::cpu_addr_t i_cpu_addr,
  input  wire loader_pkg::word_t     i_cpu_dout,
  output loader_pkg::word_t          o_cpu_din,
  output logic                       o_cpu_dtack_n,
  // CPU control
  output logic                       o_cpu_halt_n,
  output logic                       o_cpu_reset
);

  logic loader_mode;  // RAM owned by the loader

  spi_byte_if spi_bus ();
  mem_port_if mem_bus ();

  // ==================================================
  // SPI slave, word buffer, shared RAM
  // ==================================================
  spi_ram_slave spi_ram_slave_i
  (
    .clk_cpu    (clk_cpu),
    .i_rst_n    (i_rst_n),
    .i_spi_csn  (i_spi_csn),
    .i_spi_sclk (i_spi_sclk),
    .i_spi_mosi (i_spi_mosi),
    .o_spi_miso (o_spi_miso),
    .bus        (spi_bus.producer)
  );

  loader_word_buffer loader_word_buffer_i
  (
    .clk_cpu       (clk_cpu),
    .i_rst_n       (i_rst_n),
    .bus           (spi_bus.buffer),
    .mem           (mem_bus.requester),
    .o_loader_mode (loader_mode),
    .o_cpu_halt_n  (o_cpu_halt_n),
    .o_cpu_reset   (o_cpu_reset)
  );

  shared_ram
  #(
    .p_ram_words_log2 (p_ram_words_log2)
  )
  shared_ram_i
  (
    .clk_cpu       (clk_cpu),
    .i_rst_n       (i_rst_n),
    .i_loader_mode (loader_mode),
    .i_cpu_as_n    (i_cpu_as_n),
    .i_cpu_rw      (i_cpu_rw),
    .i_cpu_uds_n   (i_cpu_uds_n),
    .i_cpu_lds_n   (i_cpu_lds_n),
    .i_cpu_addr    (i_cpu_addr),
    .i_cpu_dout    (i_cpu_dout),
    .mem           (mem_bus.memory),
    .o_cpu_din     (o_cpu_din),
    .o_cpu_dtack_n (o_cpu_dtack_n)
  );

endmodule

`default_nettype wire

/* hdl/loader_word_buffer.sv */
`timescale 1ns/1ps
`default_nettype none

module loader_word_buffer
(
  input  wire           clk_cpu,
  input  wire           i_rst_n,
  spi_byte_if.buffer    bus,
  mem_port_if.requester mem,
  output logic          o_loader_mode,
  output logic          o_cpu_halt_n,
  output logic          o_cpu_reset
);
  import loader_pkg::*;

  byte_t      ctrl_q;        // CPU control register
  byte_t      slot_q [0:1];  // Slot 0 upper byte, slot 1 lower
  logic       req_q;
  logic       we_q;
  cpu_addr_t  addr_q;
  logic [1:0] rd_pipe_q;     // Read in flight, 2 stages
  logic       rd_lower_q;    // Address bit 0 of the pending read
  byte_t      rd_region_q;
  byte_t      rdata_q;
  byte_t      region;
  byte_t      ret_byte;

  assign region = bus.addr[31:24];

  // ==================================================
  // Control register and request strobes
  // ==================================================
  always_ff @(posedge clk_cpu or negedge i_rst_n)
  begin
    if (!i_rst_n)
    begin
      ctrl_q    <= CTRL_INIT;
      req_q     <= 1'b0;
      we_q      <= 1'b0;
      rd_pipe_q <= '0;
      rdata_q   <= '0;
    end
    else
    begin
      req_q     <= 1'b0;
      rd_pipe_q <= {rd_pipe_q[0], bus.rd};
      if (bus.wr && region == REGION_CTRL)
        ctrl_q <= bus.wdata;
      if (bus.wr && region == REGION_RAM && bus.addr[0])
      begin
        req_q <= 1'b1;  // Odd byte completes the word
        we_q  <= 1'b1;
      end
      if (bus.rd && region == REGION_RAM)
      begin
        req_q <= 1'b1;
        we_q  <= 1'b0;
      end
      if (rd_pipe_q[1])
        rdata_q <= ret_byte;  // RAM word is back this cycle
    end
  end

  // Byte slots and request address
  always_ff @(posedge clk_cpu)
  begin
    if (bus.wr && region == REGION_RAM)
      slot_q[bus.addr[0]] <= bus.wdata;
    if (bus.wr || bus.rd)
      addr_q <= bus.addr[23:1];
    if (bus.rd)
    begin
      rd_lower_q  <= bus.addr[0];
      rd_region_q <= region;
    end
  end

  // Pick the requested byte
  always_comb
  begin
    if (rd_region_q == REGION_RAM)
      ret_byte = rd_lower_q ? mem.rdata[7:0] : mem.rdata[15:8];
    else if (rd_region_q == REGION_CTRL)
      ret_byte = ctrl_q;
    else
      ret_byte = '0;  // Unmapped region
  end

  assign mem.req   = req_q;
  assign mem.we    = we_q;
  assign mem.addr  = addr_q;
  assign mem.wdata = {slot_q[0], slot_q[1]};  // Big-endian
  assign mem.be    = 2'b11;                   // Loader writes whole words

  assign bus.rdata = rdata_q;

  assign o_loader_mode = ctrl_q[CTRL_LOADER_BIT];
  assign o_cpu_halt_n  = ~ctrl_q[CTRL_HALT_BIT];
  assign o_cpu_reset   = ctrl_q[CTRL_RESET_BIT];

endmodule

`default_nettype wire

/* hdl/mem_port_if.sv */
`timescale 1ns/1ps
`default_nettype none

// Word requests from the word buffer to the shared RAM
interface mem_port_if;
  import loader_pkg::*;

  logic      req;    // One-cycle request strobe
  logic      we;     // 1 write, 0 read
  cpu_addr_t addr;   // Word address
  word_t     wdata;
  byte_en_t  be;     // Lane enables for writes
  word_t     rdata;  // Registered, one cycle after req

  modport requester
  (
    output req,
    output we,
    output addr,
    output wdata,
    output be,
    input  rdata
  );

  modport memory
  (
    input  req,
    input  we,
    input  addr,
    input  wdata,
    input  be,
    output rdata
  );

endinterface

`default_nettype wire

/* hdl/shared_ram.sv */
`timescale 1ns/1ps
`default_nettype none

module shared_ram
#(
  parameter int p_ram_words_log2 = 10
)
(
  input  wire                        clk_cpu,
  input  wire                        i_rst_n,
  input  wire                        i_loader_mode,
  input  wire                        i_cpu_as_n,
  input  wire                        i_cpu_rw,
  input  wire                        i_cpu_uds_n,
  input  wire                        i_cpu_lds_n,
  input  wire loader_pkg::cpu_addr_t i_cpu_addr,
  input  wire loader_pkg::word_t     i_cpu_dout,
  mem_port_if.memory                 mem,
  output loader_pkg::word_t          o_cpu_din,
  output logic                       o_cpu_dtack_n
);
  import loader_pkg::*;

  typedef enum logic [1:0]
  {
    S_IDLE,
    S_ACCESS,  // RAM read or write on this edge
    S_SETTLE,  // Capture read data
    S_ACK      // DTACK low until AS rises
  } cpu_state_t;

  word_t                       ram [0:2**p_ram_words_log2-1];
  word_t                       ram_q;
  word_t                       ram_wdata;
  byte_en_t                    ram_we;
  logic [p_ram_words_log2-1:0] ram_addr;
  cpu_state_t                  state_q;
  logic                        loader_rd_q;
  word_t                       cpu_din_q;

  // ==================================================
  // Port mux, loader mode picks the owner
  // ==================================================
  always_comb
  begin
    if (i_loader_mode)
    begin
      ram_addr  = mem.addr[p_ram_words_log2-1:0];
      ram_wdata = mem.wdata;
      ram_we    = (mem.req && mem.we) ? mem.be : 2'b00;
    end
    else
    begin
      ram_addr  = i_cpu_addr[p_ram_words_log2-1:0];
      ram_wdata = i_cpu_dout;
      ram_we    = (state_q == S_ACCESS && !i_cpu_rw) ?
                  {~i_cpu_uds_n, ~i_cpu_lds_n} : 2'b00;
    end
  end

  always_ff @(posedge clk_cpu)
  begin
    if (ram_we[1])
      ram[ram_addr][15:8] <= ram_wdata[15:8];
    if (ram_we[0])
      ram[ram_addr][7:0] <= ram_wdata[7:0];
    ram_q <= ram[ram_addr];  // Old data on a write
  end

  // ==================================================
  // CPU access FSM
  // ==================================================
  always_ff @(posedge clk_cpu or negedge i_rst_n)
  begin
    if (!i_rst_n)
    begin
      state_q     <= S_IDLE;
      loader_rd_q <= 1'b0;
      cpu_din_q   <= '0;
    end
    else
    begin
      loader_rd_q <= i_loader_mode & mem.req & ~mem.we;
      if (i_cpu_as_n || i_loader_mode)
        state_q <= S_IDLE;  // End of cycle, or CPU waits for the loader
      else
      begin
        case (state_q)
          S_IDLE:   state_q <= S_ACCESS;
          S_ACCESS: state_q <= S_SETTLE;
          S_SETTLE:
          begin
            state_q   <= S_ACK;
            cpu_din_q <= ram_q;
          end
          S_ACK:    state_q <= S_ACK;  // Hold until AS goes high
        endcase
      end
    end
  end

  // AS and loader mode release DTACK at once
  assign o_cpu_dtack_n = (state_q != S_ACK) | i_cpu_as_n | i_loader_mode;
  assign o_cpu_din     = cpu_din_q;

  // Dropped loader reads return 0
  assign mem.rdata = loader_rd_q ? ram_q : '0;

endmodule

`default_nettype wire

/* hdl/spi_byte_if.sv */
`timescale 1ns/1ps
`default_nettype none

// Byte requests from the SPI slave to the word buffer
interface spi_byte_if;
  import loader_pkg::*;

  logic      wr;     // One-cycle write strobe
  logic      rd;     // One-cycle read strobe
  spi_addr_t addr;   // Region in 31:24, byte address below
  byte_t     wdata;
  byte_t     rdata;  // Valid 3 cycles after rd

  modport producer
  (
    output wr,
    output rd,
    output addr,
    output wdata,
    input  rdata
  );

  modport buffer
  (
    input  wr,
    input  rd,
    input  addr,
    input  wdata,
    output rdata
  );

endinterface

`default_nettype wire

/* hdl/spi_ram_slave.sv */
`timescale 1ns/1ps
`default_nettype none

module spi_ram_slave
(
  input  wire          clk_cpu,
  input  wire          i_rst_n,
  input  wire          i_spi_csn,
  input  wire          i_spi_sclk,
  input  wire          i_spi_mosi,
  output logic         o_spi_miso,
  spi_byte_if.producer bus
);
  import loader_pkg::*;

  // Frame layout in byte_cnt
  localparam logic [2:0] BYTE_CMD     = 3'd0;
  localparam logic [2:0] BYTE_ADDR_LS = 3'd4;  // Last address byte
  localparam logic [2:0] BYTE_DATA_RD = 3'd6;  // Read data and saturation point

  logic [2:0] sclk_q;     // Third stage for edge detect
  logic [1:0] csn_q;
  logic [1:0] mosi_q;     // Same depth as sclk so bits line up
  logic       sclk_rise;
  logic       sclk_fall;
  logic       selected;
  logic [2:0] bit_cnt;
  logic [2:0] byte_cnt;
  logic       is_read;
  logic       is_write;
  logic       byte_done;
  logic       load_miso;
  byte_t      shift_in;
  byte_t      rx_byte;
  byte_t      shift_out;
  byte_t      wdata_q;
  spi_addr_t  addr_q;
  logic       wr_q;
  logic       rd_q;

  // ==================================================
  // Pin synchronizers
  // ==================================================
  always_ff @(posedge clk_cpu or negedge i_rst_n)
  begin
    if (!i_rst_n)
    begin
      sclk_q <= '0;
      csn_q  <= '1;  // Deselected
      mosi_q <= '0;
    end
    else
    begin
      sclk_q <= {sclk_q[1:0], i_spi_sclk};
      csn_q  <= {csn_q[0], i_spi_csn};
      mosi_q <= {mosi_q[0], i_spi_mosi};
    end
  end

  assign sclk_rise = sclk_q[1] & ~sclk_q[2];
  assign sclk_fall = ~sclk_q[1] & sclk_q[2];
  assign selected  = ~csn_q[1];

  assign rx_byte   = {shift_in[6:0], mosi_q[1]};  // MSB first
  assign byte_done = selected & sclk_rise & (bit_cnt == 3'd7);

  // ==================================================
  // Bit and byte counters, command and address
  // ==================================================
  always_ff @(posedge clk_cpu or negedge i_rst_n)
  begin
    if (!i_rst_n)
    begin
      bit_cnt  <= '0;
      byte_cnt <= '0;
      is_read  <= 1'b0;
      is_write <= 1'b0;
      addr_q   <= '0;
      wr_q     <= 1'b0;
      rd_q     <= 1'b0;
    end
    else
    begin
      wr_q <= 1'b0;
      rd_q <= 1'b0;
      if (wr_q)
        addr_q <= addr_q + 1'b1;  // Advance once the write is out
      if (!selected)
      begin
        bit_cnt  <= '0;
        byte_cnt <= '0;
      end
      else if (sclk_rise)
      begin
        bit_cnt <= bit_cnt + 1'b1;  // Wraps after 8 bits
        if (byte_done)
        begin
          if (byte_cnt != BYTE_DATA_RD)
            byte_cnt <= byte_cnt + 1'b1;
          if (byte_cnt == BYTE_CMD)
          begin
            is_read  <= (rx_byte == CMD_READ);
            is_write <= (rx_byte == CMD_WRITE);
          end
          else if (byte_cnt <= BYTE_ADDR_LS)
          begin
            addr_q <= {addr_q[23:0], rx_byte};
            rd_q   <= is_read && (byte_cnt == BYTE_ADDR_LS);  // Prefetch first byte
          end
          else if (is_write)
            wr_q <= 1'b1;
          else if (is_read && byte_cnt == BYTE_DATA_RD)
          begin
            // Fetch the next byte with the new address
            addr_q <= addr_q + 1'b1;
            rd_q   <= 1'b1;
          end
        end
      end
    end
  end

  always_ff @(posedge clk_cpu)
  begin
    if (sclk_rise)
      shift_in <= rx_byte;
    if (byte_done)
      wdata_q <= rx_byte;
  end

  // ==================================================
  // MISO shifter
  // ==================================================
  // Load on the falling edge that ends a byte in the data phase
  assign load_miso = is_read & (byte_cnt == BYTE_DATA_RD) & (bit_cnt == 3'd0);

  always_ff @(posedge clk_cpu or negedge i_rst_n)
  begin
    if (!i_rst_n)
      shift_out <= '0;
    else if (!selected)
      shift_out <= '0;  // Idle low between frames
    else if (sclk_fall)
      shift_out <= load_miso ? bus.rdata : {shift_out[6:0], 1'b0};
  end

  assign o_spi_miso = shift_out[7];

  assign bus.wr    = wr_q;
  assign bus.rd    = rd_q;
  assign bus.addr  = addr_q;
  assign bus.wdata = wdata_q;

endmodule

`default_nettype wire

/* verilog.f */
hdl/loader_pkg.sv
hdl/spi_byte_if.sv
hdl/mem_port_if.sv
hdl/spi_ram_slave.sv
hdl/loader_word_buffer.sv
hdl/shared_ram.sv
hdl/loader_top.sv
bench/tb_clock_gen.sv
bench/loader_top_sva.sv
bench/tb_loader_top.sv
